// ==== Bender.yml ====
package:
  name: zet_wb

sources:
  - rtl/zet_pkg.sv
  - rtl/zet_wb_fsm.sv
  - rtl/zet_wb_watchdog.sv
  - rtl/zet_wb_lanes.sv
  - rtl/zet_wb_rdata.sv
  - rtl/zet_wb_master.sv
  - target: simulation
    files:
      - verif/zet_wb_master_tb.sv

// ==== rtl/zet_pkg.sv ====
// zet_pkg: bus widths, watchdog limit, open-bus value, fsm state and port enums
package zet_pkg;

  // micro-interface and wishbone widths
  localparam int ADR_W = 20;  // byte address
  localparam int DAT_W = 16;  // one 16-bit word
  localparam int SEL_W = DAT_W / 8;  // byte lanes on the bus

  // wait cycles per beat before the access is abandoned
  localparam int WB_TIMEOUT_CYCLES = 16;
  localparam int WDOG_W = $clog2(WB_TIMEOUT_CYCLES + 1);  // counter must hold the limit itself

  // what a read sees when nobody answers
  localparam logic [DAT_W-1:0] OPEN_BUS_DATA = '1;

  // sequencing of one access
  // BEAT2 only for a word at an odd address
  typedef enum logic [1:0] {
    IDLE,   // waiting for a stb
    BEAT1,  // first (or only) wishbone beat
    BEAT2,  // high byte of a split word
    DONE    // ack back to the requester
  } umi_state_e;

  // who owns the current access
  typedef enum logic {
    PORT_FETCH,  // umif, read only
    PORT_EXEC    // umie, has priority
  } umi_port_e;

endpackage

// ==== rtl/zet_wb_fsm.sv ====
// zet_wb_fsm: requester arbitration, wishbone beat sequencing and umi ack generation
`timescale 1ns/1ps

module zet_wb_fsm (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   umif_stb_i,     // fetch request level
  input  logic                   umie_stb_i,     // exec request level
  input  logic                   split_i,        // granted word is misaligned
  input  logic                   wb_ack_i,
  input  logic                   expire_i,       // watchdog gave up on this beat
  output zet_pkg::umi_state_e    state_o,
  output zet_pkg::umi_port_e     grant_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   beat_active_o,  // to watchdog
  output logic                   umif_ack_o,
  output logic                   umie_ack_o
);

  import zet_pkg::*;

  umi_state_e state_q, state_d;
  umi_port_e  grant_q, grant_d;
  logic       umif_ack_q;
  logic       umie_ack_q;

  // next state
  always_comb begin
    state_d = state_q;
    grant_d = grant_q;
    case (state_q)
      IDLE: begin
        // exec wins when both ask in the same cycle
        if (umie_stb_i) begin
          grant_d = PORT_EXEC;
          state_d = BEAT1;
        end else if (umif_stb_i) begin
          grant_d = PORT_FETCH;
          state_d = BEAT1;
        end
      end
      BEAT1: begin
        if (expire_i) begin
          state_d = DONE;  // abort, second beat skipped too
        end else if (wb_ack_i) begin
          state_d = split_i ? BEAT2 : DONE;
        end
      end
      BEAT2: begin
        if (expire_i || wb_ack_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        state_d = IDLE;  // ack lasts this one cycle
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // state, grant and the registered acks
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      grant_q    <= PORT_FETCH;
      umif_ack_q <= 1'b0;
      umie_ack_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      grant_q    <= grant_d;
      // high exactly while in DONE
      umif_ack_q <= (state_d == DONE) && (grant_q == PORT_FETCH);
      umie_ack_q <= (state_d == DONE) && (grant_q == PORT_EXEC);
    end
  end

  // bus strobes follow the beat states directly
  // BEAT1 to BEAT2 keeps them high, a new beat on the next edge
  assign wb_stb_o      = (state_q == BEAT1) || (state_q == BEAT2);
  assign wb_cyc_o      = wb_stb_o;
  assign beat_active_o = wb_stb_o;

  assign state_o    = state_q;
  assign grant_o    = grant_q;
  assign umif_ack_o = umif_ack_q;
  assign umie_ack_o = umie_ack_q;

endmodule

// ==== rtl/zet_wb_lanes.sv ====
// zet_wb_lanes: granted request mux, split detect, word address, byte selects and write lanes
`timescale 1ns/1ps

module zet_wb_lanes (
  input  zet_pkg::umi_port_e                grant_i,
  input  zet_pkg::umi_state_e               state_i,
  input  logic [zet_pkg::ADR_W-1:0]         umif_adr_i,
  input  logic                              umif_by_i,
  input  logic [zet_pkg::ADR_W-1:0]         umie_adr_i,
  input  logic [zet_pkg::DAT_W-1:0]         umie_dat_i,
  input  logic                              umie_we_i,
  input  logic                              umie_by_i,
  input  logic                              umie_tga_i,
  output logic [zet_pkg::ADR_W-1:1]         wb_adr_o,
  output logic [zet_pkg::DAT_W-1:0]         wb_dat_o,
  output logic                              wb_we_o,
  output logic                              wb_tga_o,   // io space
  output logic [zet_pkg::SEL_W-1:0]         wb_sel_o,
  output logic                              split_o
);

  import zet_pkg::*;

  logic             exec;
  logic [ADR_W-1:0] adr;
  logic             by;
  logic             beat2;

  assign exec  = (grant_i == PORT_EXEC);
  assign adr   = exec ? umie_adr_i : umif_adr_i;
  assign by    = exec ? umie_by_i : umif_by_i;
  assign beat2 = (state_i == BEAT2);

  // word at odd byte address needs two beats
  assign split_o = !by && adr[0];

  // fetch is always a memory read
  assign wb_we_o  = exec && umie_we_i;
  assign wb_tga_o = exec && umie_tga_i;

  // second beat moves on to the next word
  assign wb_adr_o = beat2 ? adr[ADR_W-1:1] + (ADR_W-1)'(1) : adr[ADR_W-1:1];

  always_comb begin
    if (split_o) begin
      wb_sel_o = beat2 ? 2'b01 : 2'b10;
      wb_dat_o = beat2 ? {8'h00, umie_dat_i[15:8]}   // high byte into low lane
                       : {umie_dat_i[7:0], 8'h00};   // low byte into high lane
    end else if (by) begin
      wb_sel_o = adr[0] ? 2'b10 : 2'b01;             // lane follows bit 0
      wb_dat_o = adr[0] ? {umie_dat_i[7:0], 8'h00} : {8'h00, umie_dat_i[7:0]};
    end else begin
      wb_sel_o = 2'b11;  // aligned word
      wb_dat_o = umie_dat_i;
    end
  end

endmodule

// ==== rtl/zet_wb_master.sv ====
// zet_wb_master: fetch and exec micro-interfaces onto one 16-bit wishbone master
`timescale 1ns/1ps

module zet_wb_master (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // fetch port, read only
  input  logic [zet_pkg::ADR_W-1:0]   umif_adr_i,
  output logic [zet_pkg::DAT_W-1:0]   umif_dat_o,
  input  logic                        umif_stb_i,
  input  logic                        umif_by_i,
  output logic                        umif_ack_o,

  // exec port
  input  logic [zet_pkg::ADR_W-1:0]   umie_adr_i,
  output logic [zet_pkg::DAT_W-1:0]   umie_dat_o,
  input  logic [zet_pkg::DAT_W-1:0]   umie_dat_i,
  input  logic                        umie_we_i,
  input  logic                        umie_by_i,
  input  logic                        umie_stb_i,
  output logic                        umie_ack_o,
  input  logic                        umie_tga_i,  // io/mem

  // wishbone master
  input  logic [zet_pkg::DAT_W-1:0]   wb_dat_i,
  output logic [zet_pkg::DAT_W-1:0]   wb_dat_o,
  output logic [zet_pkg::ADR_W-1:1]   wb_adr_o,
  output logic                        wb_we_o,
  output logic                        wb_tga_o,
  output logic [zet_pkg::SEL_W-1:0]   wb_sel_o,
  output logic                        wb_stb_o,
  output logic                        wb_cyc_o,
  input  logic                        wb_ack_i
);

  import zet_pkg::*;

  umi_state_e       state;
  umi_port_e        grant;
  logic             split;
  logic             beat_active;
  logic             expire;
  logic [DAT_W-1:0] umi_dat;

  zet_wb_fsm fsm0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .umif_stb_i    (umif_stb_i),
    .umie_stb_i    (umie_stb_i),
    .split_i       (split),
    .wb_ack_i      (wb_ack_i),
    .expire_i      (expire),
    .state_o       (state),
    .grant_o       (grant),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .beat_active_o (beat_active),
    .umif_ack_o    (umif_ack_o),
    .umie_ack_o    (umie_ack_o)
  );

  zet_wb_watchdog wdog0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .beat_active_i (beat_active),
    .wb_ack_i      (wb_ack_i),
    .expire_o      (expire)
  );

  zet_wb_lanes lanes0 (
    .grant_i    (grant),
    .state_i    (state),
    .umif_adr_i (umif_adr_i),
    .umif_by_i  (umif_by_i),
    .umie_adr_i (umie_adr_i),
    .umie_dat_i (umie_dat_i),
    .umie_we_i  (umie_we_i),
    .umie_by_i  (umie_by_i),
    .umie_tga_i (umie_tga_i),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_o   (wb_dat_o),
    .wb_we_o    (wb_we_o),
    .wb_tga_o   (wb_tga_o),
    .wb_sel_o   (wb_sel_o),
    .split_o    (split)
  );

  // sel tells rdata which lanes came back
  zet_wb_rdata rdata0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .state_i    (state),
    .split_i    (split),
    .wb_ack_i   (wb_ack_i),
    .expire_i   (expire),
    .wb_dat_i   (wb_dat_i),
    .byte_sel_i (wb_sel_o),
    .umi_dat_o  (umi_dat)
  );

  // one result register, each port only sees it with its own ack
  assign umif_dat_o = umif_ack_o ? umi_dat : '0;
  assign umie_dat_o = umie_ack_o ? umi_dat : '0;

endmodule

// ==== rtl/zet_wb_rdata.sv ====
// zet_wb_rdata: read lane capture, split word reassembly and open-bus result on expiry
`timescale 1ns/1ps

module zet_wb_rdata (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  zet_pkg::umi_state_e        state_i,
  input  logic                       split_i,
  input  logic                       wb_ack_i,
  input  logic                       expire_i,
  input  logic [zet_pkg::DAT_W-1:0]  wb_dat_i,
  input  logic [zet_pkg::SEL_W-1:0]  byte_sel_i,  // lanes of the current beat
  output logic [zet_pkg::DAT_W-1:0]  umi_dat_o
);

  import zet_pkg::*;

  logic [DAT_W-1:0] res_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_q <= '0;
    end else if (expire_i) begin
      res_q <= OPEN_BUS_DATA;  // nobody answered
    end else if (wb_ack_i && state_i == BEAT2 && split_i) begin
      res_q[15:8] <= wb_dat_i[7:0];  // second half of a split word
    end else if (wb_ack_i && state_i == BEAT1) begin
      // high lane alone is an odd byte or the first half of a split
      case (byte_sel_i)
        2'b01:   res_q <= {8'h00, wb_dat_i[7:0]};
        2'b10:   res_q <= {8'h00, wb_dat_i[15:8]};
        default: res_q <= wb_dat_i;
      endcase
    end
  end

  assign umi_dat_o = res_q;  // steady through DONE

endmodule

// ==== rtl/zet_wb_watchdog.sv ====
// zet_wb_watchdog: wait-cycle counter per wishbone beat with expiry pulse
`timescale 1ns/1ps

module zet_wb_watchdog (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic beat_active_i,  // stb/cyc of the current beat
  input  logic wb_ack_i,
  output logic expire_o        // one cycle, aborts the access
);

  import zet_pkg::*;

  logic [WDOG_W-1:0] cnt_q;

  // limit reached while still waiting
  assign expire_o = beat_active_i && (cnt_q == WDOG_W'(WB_TIMEOUT_CYCLES));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!beat_active_i || wb_ack_i || expire_o) begin
      cnt_q <= '0;  // idle bus, beat done, or just fired
    end else begin
      cnt_q <= cnt_q + 1'b1;  // one more wait state
    end
  end

endmodule

// ==== verif/zet_wb_master_tb.sv ====
// zet_wb_master_tb: clock, reset, vector reader, requester driver, wishbone memory model, checks
`timescale 1ns/1ps

module zet_wb_master_tb;

  import zet_pkg::*;

  logic             clk_i;
  logic             rst_n_i;
  logic [ADR_W-1:0] umif_adr_i;
  logic [ADR_W-1:0] umie_adr_i;
  logic [DAT_W-1:0] umif_dat_o;
  logic [DAT_W-1:0] umie_dat_o;
  logic [DAT_W-1:0] umie_dat_i;
  logic             umif_stb_i, umif_by_i, umif_ack_o;
  logic             umie_we_i, umie_by_i, umie_stb_i, umie_ack_o, umie_tga_i;
  logic [DAT_W-1:0] wb_dat_i;
  logic [DAT_W-1:0] wb_dat_o;
  logic [ADR_W-1:1] wb_adr_o;
  logic [SEL_W-1:0] wb_sel_o;
  logic             wb_we_o, wb_tga_o, wb_stb_o, wb_cyc_o, wb_ack_i;

  // one entry per vector line including the B markers
  byte              v_port[$];
  logic             v_we[$];
  logic             v_by[$];
  logic             v_tga[$];
  logic [ADR_W-1:0] v_adr[$];
  logic [DAT_W-1:0] v_wdat[$];
  logic [DAT_W-1:0] v_rdat[$];

  logic [DAT_W-1:0] mem [0:4095];  // slave storage, low word-address bits
  logic [11:0]      mem_idx;
  logic [31:0]      lfsr;
  logic             busy;          // slave is counting wait states
  int               wait_left;
  int               cycle_cnt;
  int               cycle_limit;   // 0 until the vectors are known

  zet_wb_master dut0 (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run("value check failed, stopping at first error");
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic int draw_wait();
    int n;
    n = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      n = (n << 1) | lfsr[0];
    end
    return n;
  endfunction

  // wishbone beats the access should take
  function automatic int expect_beats(input logic [ADR_W-1:0] adr, input logic by);
    if (adr[ADR_W-1:16] == 4'hf) return 0;  // nobody answers up there
    return (!by && adr[0]) ? 2 : 1;
  endfunction

  // memory slave with 0..3 wait states
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_i <= 1'b0;
      busy     <= 1'b0;
    end else if (wb_ack_i) begin
      wb_ack_i <= 1'b0;  // ack lasts one cycle
      busy     <= 1'b0;
    end else if (wb_cyc_o && wb_stb_o && wb_adr_o[ADR_W-1:16] != 4'hf) begin
      wait_left = busy ? wait_left - 1 : draw_wait();
      busy <= 1'b1;
      if (wait_left == 0) begin
        mem_idx = wb_adr_o[12:1];
        if (wb_we_o && wb_sel_o[0]) mem[mem_idx][7:0] = wb_dat_o[7:0];
        if (wb_we_o && wb_sel_o[1]) mem[mem_idx][15:8] = wb_dat_o[15:8];
        wb_dat_i <= mem[mem_idx];
        wb_ack_i <= 1'b1;
      end
    end else begin
      busy <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
      abort_run("timeout, an access never returned its ack");
  end

  task automatic load_vectors(output int n_acc);
    int               fd;
    int               cnt;
    string            line;
    byte              port;
    logic             we, by, tga;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] wdat, rdat;
    n_acc = 0;
    fd = $fopen("verif/zet_wb_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open verif/zet_wb_vectors.txt");
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
        if (line[0] == "B") begin
          cnt = 7;
          {port, we, by, tga, adr, wdat, rdat} = {"B", 3'b000, 20'h0, 32'h0};
        end else begin
          cnt = $sscanf(line, "%c %h %h %h %h %h %h", port, we, by, tga, adr, wdat, rdat);
          n_acc++;
        end
        if (cnt != 7) abort_run({"bad vector line: ", line});
        v_port.push_back(port);
        v_we.push_back(we);
        v_by.push_back(by);
        v_tga.push_back(tga);
        v_adr.push_back(adr);
        v_wdat.push_back(wdat);
        v_rdat.push_back(rdat);
      end
      $fclose(fd);
    end
  endtask

  // raise one or both stb together and follow the acks
  // index -1 leaves that port idle
  task automatic run_access(input int ie, input int ifc);
    bit   pend_e, pend_f;
    int   e_hs, f_hs;
    logic e_tga, f_tga;
    pend_e = (ie >= 0);
    pend_f = (ifc >= 0);
    e_hs   = 0;
    f_hs   = 0;
    e_tga  = 1'b0;
    f_tga  = 1'b0;
    @(posedge clk_i);
    if (pend_e) begin
      umie_adr_i <= v_adr[ie];
      umie_dat_i <= v_wdat[ie];
      umie_we_i  <= v_we[ie];
      umie_by_i  <= v_by[ie];
      umie_tga_i <= v_tga[ie];
      umie_stb_i <= 1'b1;
    end else begin
      umie_tga_i <= 1'b1;  // idle exec fields a fetch must ignore
      umie_we_i  <= 1'b1;
    end
    if (pend_f) begin
      umif_adr_i <= v_adr[ifc];
      umif_by_i  <= v_by[ifc];
      umif_stb_i <= 1'b1;
    end
    while (pend_e || pend_f) begin
      @(posedge clk_i);
      if (wb_stb_o && wb_ack_i) begin  // beats belong to exec while it is pending
        if (pend_e) e_hs++;
        else f_hs++;
        if (pend_e) e_tga = e_tga | wb_tga_o;
        else f_tga = f_tga | wb_tga_o;
      end
      if (umie_ack_o) begin
        compare("umie_ack_o", pend_e, 1'b1);
        compare("wb_cyc_o", wb_cyc_o, 1'b0);
        compare("umie wishbone beats", e_hs, expect_beats(v_adr[ie], v_by[ie]));
        compare("wb_tga_o", e_tga, v_tga[ie] && expect_beats(v_adr[ie], v_by[ie]) > 0);
        if (!v_we[ie]) compare("umie_dat_o", umie_dat_o, v_rdat[ie]);
        pend_e = 1'b0;
        umie_stb_i <= 1'b0;
      end
      if (umif_ack_o) begin
        compare("umif_ack_o", pend_f, 1'b1);
        compare("umif_ack_o after umie_ack_o", pend_e | umie_ack_o, 1'b0);
        compare("wb_cyc_o", wb_cyc_o, 1'b0);
        compare("umif wishbone beats", f_hs, expect_beats(v_adr[ifc], v_by[ifc]));
        compare("wb_tga_o on fetch", f_tga, 1'b0);
        compare("umif_dat_o", umif_dat_o, v_rdat[ifc]);
        pend_f = 1'b0;
        umif_stb_i <= 1'b0;
      end
    end
  endtask

  task automatic check_idle_bus();
    compare("wb_cyc_o", wb_cyc_o, 1'b0);
    compare("wb_stb_o", wb_stb_o, 1'b0);
    compare("umie_ack_o", umie_ack_o, 1'b0);
    compare("umif_ack_o", umif_ack_o, 1'b0);
  endtask

  initial begin
    int i;
    int n_acc;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    {umif_adr_i, umif_stb_i, umif_by_i} = '0;
    {umie_adr_i, umie_dat_i, umie_we_i, umie_by_i, umie_stb_i, umie_tga_i} = '0;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    lfsr = 32'h8c28;
    busy = 1'b0;
    wait_left = 0;
    cycle_cnt = 0;
    cycle_limit = 0;
    for (int k = 0; k < 4096; k++) mem[k] = 16'(k) ^ 16'h5a00;  // every index distinct
    load_vectors(n_acc);
    cycle_limit = n_acc * (2 * WB_TIMEOUT_CYCLES + 8) + 16;  // plus reset and tail
    @(posedge clk_i);  // first edge applies the reset
    repeat (4) begin
      @(posedge clk_i);
      check_idle_bus();
    end
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_idle_bus();  // first cycle out of reset
    i = 0;
    while (i < v_port.size()) begin
      if (v_port[i] == "B") begin
        run_access(i + 1, i + 2);  // E line then F line
        i += 3;
      end else begin
        if (v_port[i] == "E") run_access(i, -1);
        else run_access(-1, i);
        i++;
      end
    end
    repeat (2) @(posedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== verif/zet_wb_vectors.txt ====
# port(E exec, F fetch, B = next E and F lines start together) we by tga adr wdat rdat
# all hex; rdat checked on reads only; adr with bits 19:16 = f never gets a slave ack
E 1 0 0 00100 1234 0000
E 0 0 0 00100 0000 1234
F 0 0 0 00100 0000 1234
E 1 0 1 00200 beef 0000
E 0 0 1 00200 0000 beef
E 1 1 0 00101 77ab 0000
E 1 1 0 00100 00cd 0000
E 0 0 0 00100 0000 abcd
E 0 1 0 00101 0000 00ab
F 0 1 0 00100 0000 00cd
E 1 0 0 00301 5678 0000
E 0 0 0 00301 0000 5678
E 0 0 0 00300 0000 7880
E 0 0 0 00302 0000 5b56
F 0 0 0 00301 0000 5678
E 0 1 0 00301 0000 0078
B
E 1 0 0 00400 9abc 0000
F 0 0 0 00100 0000 abcd
B
E 0 0 0 00400 0000 9abc
F 0 0 0 00200 0000 beef
E 0 0 0 f0000 0000 ffff
E 0 0 0 00400 0000 9abc
F 0 0 0 f0010 0000 ffff
F 0 0 0 00102 0000 5a81

// ==== zet_wb.f ====
rtl/zet_pkg.sv
rtl/zet_wb_fsm.sv
rtl/zet_wb_watchdog.sv
rtl/zet_wb_lanes.sv
rtl/zet_wb_rdata.sv
rtl/zet_wb_master.sv
verif/zet_wb_master_tb.sv
